// ==== design/pi_cart_pkg.sv ====
package pi_cart_pkg;

    localparam int PI_SYNC_STAGES = 3;
    localparam int FIFO_DEPTH = 4;
    localparam int MEM_ADDR_BITS = 12; // Byte address bits, 2048 words
    localparam int ACK_LATENCY = 2;

    typedef logic [15:0] pi_word_t;

    typedef enum logic [1:0] {
        REGION_NONE,
        REGION_ROM,
        REGION_SAVE
    } pi_region_e;

    typedef struct packed {
        logic save_enabled;
        logic rom_writable;
        logic [31:0] rom_offset;
        logic [31:0] save_offset;
    } pi_config_t;

    typedef struct packed {
        logic aleh_op;
        logic alel_op;
        logic read_op;
        logic write_op;
        logic end_op;
    } pi_events_t;

    typedef struct packed {
        logic request;
        logic write;
        logic [31:0] address;
        pi_word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic ack;
        pi_word_t rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic valid;
        logic writable;
        pi_region_e region;
        logic [31:0] start_address; // Offset already applied
    } pi_target_t;

endpackage

// ==== design/pi_fifo.sv ====
`timescale 1ns/1ns

module pi_fifo
    import pi_cart_pkg::*;
(
    input logic sys,
    input logic rst,
    input logic flush,
    input logic write,
    input pi_word_t wdata,
    output logic full,
    input logic read,
    output pi_word_t rdata,
    output logic empty
);

    pi_word_t buffer [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH):0] write_ptr; // Extra bit tells full from empty
    logic [$clog2(FIFO_DEPTH):0] read_ptr;

    always_comb begin
        empty = write_ptr == read_ptr;
        full = (write_ptr[$clog2(FIFO_DEPTH)] != read_ptr[$clog2(FIFO_DEPTH)]) &&
               (write_ptr[$clog2(FIFO_DEPTH)-1:0] == read_ptr[$clog2(FIFO_DEPTH)-1:0]);
        rdata = buffer[read_ptr[$clog2(FIFO_DEPTH)-1:0]]; // Show-ahead head word
    end

    always_ff @(posedge sys) begin
        if (write && !full) begin
            buffer[write_ptr[$clog2(FIFO_DEPTH)-1:0]] <= wdata;
        end
    end

    always_ff @(posedge sys) begin
        if (rst || flush) begin
            write_ptr <= '0;
            read_ptr <= '0;
        end else begin
            if (write && !full) begin
                write_ptr <= write_ptr + 1'b1;
            end
            if (read && !empty) begin
                read_ptr <= read_ptr + 1'b1;
            end
        end
    end

    a_no_overflow: assert property (@(posedge sys) disable iff (rst) write && !flush |-> !full);
    a_no_underflow: assert property (@(posedge sys) disable iff (rst) read && !flush |-> !empty);

endmodule

// ==== design/pi_bus_frontend.sv ====
`timescale 1ns/1ns

module pi_bus_frontend
    import pi_cart_pkg::*;
(
    input logic sys,
    input logic rst,
    input logic alel,
    input logic aleh,
    input logic read,
    input logic write,
    inout pi_word_t ad,
    output pi_word_t ad_in,
    output pi_events_t events,
    input pi_word_t ad_out,
    input logic ad_out_valid,
    input logic drive_enable
);

    typedef enum logic [1:0] {
        MODE_IDLE = 2'b10,
        MODE_HIGH = 2'b11,
        MODE_LOW = 2'b01,
        MODE_VALID = 2'b00
    } pi_mode_e;

    logic [PI_SYNC_STAGES-1:0] aleh_ff;
    logic [PI_SYNC_STAGES-1:0] alel_ff;
    logic [PI_SYNC_STAGES-1:0] read_ff;
    logic [PI_SYNC_STAGES-1:0] write_ff;
    logic read_s;
    logic write_s;
    logic last_read;
    logic last_write;
    pi_mode_e mode;
    pi_mode_e last_mode;
    pi_word_t ad_q;
    logic ad_oe;

    always_ff @(posedge sys) begin
        if (rst) begin
            aleh_ff <= '1; // Bus rests in idle mode
            alel_ff <= '0;
            read_ff <= '1;
            write_ff <= '1;
            last_mode <= MODE_IDLE;
            last_read <= 1'b1;
            last_write <= 1'b1;
        end else begin
            aleh_ff <= {aleh_ff[PI_SYNC_STAGES-2:0], aleh};
            alel_ff <= {alel_ff[PI_SYNC_STAGES-2:0], alel};
            read_ff <= {read_ff[PI_SYNC_STAGES-2:0], read};
            write_ff <= {write_ff[PI_SYNC_STAGES-2:0], write};
            last_mode <= mode;
            last_read <= read_s;
            last_write <= write_s;
        end
    end

    always_comb begin
        mode = pi_mode_e'({aleh_ff[PI_SYNC_STAGES-1], alel_ff[PI_SYNC_STAGES-1]});
        read_s = read_ff[PI_SYNC_STAGES-1];
        write_s = write_ff[PI_SYNC_STAGES-1];
        events.aleh_op = last_mode != MODE_HIGH && mode == MODE_HIGH;
        events.alel_op = last_mode == MODE_HIGH && mode == MODE_LOW;
        events.read_op = mode == MODE_VALID && last_read && !read_s;
        events.write_op = mode == MODE_VALID && last_write && !write_s;
        events.end_op = last_mode == MODE_VALID && mode != MODE_VALID;
    end

    always_ff @(posedge sys) begin
        ad_in <= ad;
        if (ad_out_valid) begin
            ad_q <= ad_out; // Word popped for the current read
        end
    end

    always_ff @(posedge sys) begin
        if (rst) begin
            ad_oe <= 1'b0;
        end else begin
            ad_oe <= mode == MODE_VALID && drive_enable && !read_s;
        end
    end

    assign ad = ad_oe ? ad_q : 'z;

endmodule

// ==== design/pi_address_decode.sv ====
`timescale 1ns/1ns

module pi_address_decode
    import pi_cart_pkg::*;
(
    input logic sys,
    input logic rst,
    input pi_config_t cfg,
    input pi_events_t events,
    input pi_word_t ad_in,
    output pi_target_t target,
    output logic load_next
);

    logic rom_hit;
    logic save_hit;
    pi_word_t high_half;
    pi_region_e next_region;
    logic [31:0] next_offset;

    always_comb begin
        rom_hit = ad_in >= 16'h1000 && ad_in < 16'h1400;
        save_hit = cfg.save_enabled && ad_in == 16'h0800;
    end

    // The high phase picks the region and the low phase finishes the address
    always_ff @(posedge sys) begin
        if (events.aleh_op) begin
            high_half <= ad_in;
            next_region <= REGION_NONE;
            next_offset <= 32'd0;
            if (rom_hit) begin
                next_region <= REGION_ROM;
                next_offset <= cfg.rom_offset - 32'h1000_0000;
            end
            if (save_hit) begin
                next_region <= REGION_SAVE;
                next_offset <= cfg.save_offset - 32'h0800_0000;
            end
        end
    end

    always_ff @(posedge sys) begin
        if (rst) begin
            target <= '0;
            load_next <= 1'b0;
        end else begin
            load_next <= events.alel_op;
            if (events.aleh_op) begin
                target.valid <= 1'b0;
            end
            if (events.alel_op) begin
                target.valid <= next_region != REGION_NONE &&
                                !(next_region == REGION_SAVE && ad_in[15]); // Save is 32 KiB
                target.region <= next_region;
                target.writable <= next_region == REGION_SAVE ||
                                   (next_region == REGION_ROM && cfg.rom_writable);
                target.start_address <= {high_half, ad_in[15:1], 1'b0} + next_offset;
            end
        end
    end

    // The address word has settled on AD before its phase is decoded
    a_address_settled: assert property (@(posedge sys) disable iff (rst)
        (events.aleh_op || events.alel_op) |-> $stable(ad_in));

endmodule

// ==== design/pi_bus_controller.sv ====
`timescale 1ns/1ns

module pi_bus_controller
    import pi_cart_pkg::*;
(
    input logic sys,
    input logic rst,
    input pi_events_t events,
    input pi_target_t target,
    input logic load_next,
    input pi_word_t ad_in,
    output logic read_flush,
    input logic read_full,
    output logic read_push,
    output pi_word_t read_data,
    input logic read_empty,
    output logic read_pop,
    input pi_word_t read_word,
    output logic write_flush,
    input logic write_full,
    output logic write_push,
    output pi_word_t write_data,
    input logic write_empty,
    output logic write_pop,
    input pi_word_t write_word,
    output mem_req_t mem_req,
    input mem_rsp_t mem_rsp,
    output pi_word_t ad_out,
    output logic ad_out_valid
);

    logic wait_read;
    logic wait_write;
    logic can_read;
    logic first_write;
    logic load_start;

    always_comb begin
        read_push = mem_rsp.ack && !mem_req.write;
        read_data = mem_rsp.rdata;
        write_data = ad_in;
        ad_out = read_word;
        ad_out_valid = read_pop;
    end

    // A console strobe against an empty or full FIFO waits here
    always_ff @(posedge sys) begin
        if (rst) begin
            wait_read <= 1'b0;
            wait_write <= 1'b0;
            read_pop <= 1'b0;
            write_push <= 1'b0;
        end else begin
            read_pop <= 1'b0;
            write_push <= 1'b0;
            if (target.valid) begin
                if (events.read_op || wait_read) begin
                    wait_read <= read_empty;
                    read_pop <= !read_empty;
                end
                if (events.write_op || wait_write) begin
                    wait_write <= write_full;
                    write_push <= !write_full;
                end
            end
        end
    end

    always_ff @(posedge sys) begin
        if (rst) begin
            mem_req.request <= 1'b0;
            read_flush <= 1'b1;
            write_flush <= 1'b1;
            write_pop <= 1'b0;
            can_read <= 1'b0;
            first_write <= 1'b0;
            load_start <= 1'b0;
        end else begin
            read_flush <= load_next;
            write_flush <= !target.writable;
            write_pop <= 1'b0;
            if (load_next) begin
                can_read <= 1'b1;
                first_write <= 1'b1;
                load_start <= 1'b1;
            end
            if (events.write_op) begin
                can_read <= 1'b0;
                first_write <= 1'b0;
                load_start <= load_start || first_write; // Undo the prefetch advance
            end
            if (events.end_op) begin
                can_read <= 1'b0;
            end
            if (!mem_req.request) begin
                if (!write_empty) begin
                    mem_req.request <= 1'b1;
                    mem_req.write <= 1'b1;
                    mem_req.wdata <= write_word;
                    write_pop <= 1'b1;
                end else if (!read_full && can_read) begin
                    mem_req.request <= 1'b1;
                    mem_req.write <= 1'b0;
                end
                if (!write_empty || (!read_full && can_read)) begin
                    if (load_start) begin
                        mem_req.address <= target.start_address;
                        load_start <= 1'b0;
                    end
                end
            end else if (mem_rsp.ack) begin
                mem_req.request <= 1'b0;
                mem_req.address <= mem_req.address + 32'd2;
            end
        end
    end

    // The memory answers only a request that is still open
    a_ack_with_request: assert property (@(posedge sys) disable iff (rst)
        mem_rsp.ack |-> mem_req.request);

endmodule

// ==== design/cart_memory.sv ====
`timescale 1ns/1ns

module cart_memory
    import pi_cart_pkg::*;
(
    input logic sys,
    input logic rst,
    input mem_req_t mem_req,
    output mem_rsp_t mem_rsp
);

    pi_word_t mem [2**(MEM_ADDR_BITS-1)];
    logic [$clog2(ACK_LATENCY+1)-1:0] count;
    logic ack_q;
    pi_word_t rdata_q;
    logic fire;

    always_comb begin
        fire = mem_req.request && !ack_q && count == ACK_LATENCY - 1;
        mem_rsp.ack = ack_q;
        mem_rsp.rdata = rdata_q;
    end

    always_ff @(posedge sys) begin
        if (rst) begin
            count <= '0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= fire; // Single pulse per request
            if (!mem_req.request || ack_q) begin
                count <= '0;
            end else if (count != ACK_LATENCY) begin
                count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge sys) begin
        if (fire) begin
            rdata_q <= mem[mem_req.address[MEM_ADDR_BITS-1:1]];
            if (mem_req.write) begin
                mem[mem_req.address[MEM_ADDR_BITS-1:1]] <= mem_req.wdata;
            end
        end
    end

endmodule

// ==== design/pi_cart_top.sv ====
`timescale 1ns/1ns

module pi_cart_top
    import pi_cart_pkg::*;
(
    input logic sys,
    input logic rst,
    input pi_config_t cfg,
    input logic alel,
    input logic aleh,
    input logic read,
    input logic write,
    inout pi_word_t ad
);

    pi_events_t events;
    pi_word_t ad_in;
    pi_word_t ad_out;
    logic ad_out_valid;
    pi_target_t target;
    logic load_next;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    logic read_flush;
    logic read_full;
    logic read_push;
    pi_word_t read_data;
    logic read_empty;
    logic read_pop;
    pi_word_t read_word;

    logic write_flush;
    logic write_full;
    logic write_push;
    pi_word_t write_data;
    logic write_empty;
    logic write_pop;
    pi_word_t write_word;

    pi_bus_frontend i_pi_bus_frontend (
        .sys(sys),
        .rst(rst),
        .alel(alel),
        .aleh(aleh),
        .read(read),
        .write(write),
        .ad(ad),
        .ad_in(ad_in),
        .events(events),
        .ad_out(ad_out),
        .ad_out_valid(ad_out_valid),
        .drive_enable(target.valid)
    );

    pi_address_decode i_pi_address_decode (
        .sys(sys),
        .rst(rst),
        .cfg(cfg),
        .events(events),
        .ad_in(ad_in),
        .target(target),
        .load_next(load_next)
    );

    pi_bus_controller i_pi_bus_controller (
        .sys(sys),
        .rst(rst),
        .events(events),
        .target(target),
        .load_next(load_next),
        .ad_in(ad_in),
        .read_flush(read_flush),
        .read_full(read_full),
        .read_push(read_push),
        .read_data(read_data),
        .read_empty(read_empty),
        .read_pop(read_pop),
        .read_word(read_word),
        .write_flush(write_flush),
        .write_full(write_full),
        .write_push(write_push),
        .write_data(write_data),
        .write_empty(write_empty),
        .write_pop(write_pop),
        .write_word(write_word),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp),
        .ad_out(ad_out),
        .ad_out_valid(ad_out_valid)
    );

    pi_fifo i_read_fifo (
        .sys(sys),
        .rst(rst),
        .flush(read_flush),
        .write(read_push),
        .wdata(read_data),
        .full(read_full),
        .read(read_pop),
        .rdata(read_word),
        .empty(read_empty)
    );

    pi_fifo i_write_fifo (
        .sys(sys),
        .rst(rst),
        .flush(write_flush),
        .write(write_push),
        .wdata(write_data),
        .full(write_full),
        .read(write_pop),
        .rdata(write_word),
        .empty(write_empty)
    );

    cart_memory i_cart_memory (
        .sys(sys),
        .rst(rst),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp)
    );

endmodule

// ==== tests/pi_cart_tb.sv ====
`timescale 1ns/1ns

module pi_cart_tb
    import pi_cart_pkg::*;
();

    localparam int PERIOD = 100;
    localparam int DRIVE_DELAY = 10;
    localparam int PHASE = 8; // Cycles per bus phase and per strobe high time
    localparam int STROBE_LOW = 24;
    localparam int NUM_TESTS = 6;
    localparam int BURST_CYCLES = 4 * PHASE + 16 * (STROBE_LOW + PHASE);
    localparam int TIMEOUT_NS = NUM_TESTS * BURST_CYCLES * 2 * PERIOD;
    localparam pi_word_t IDLE_AD = 16'hffff; // Pulled-up value of an undriven bus

    typedef struct packed {
        logic valid;
        logic writable;
        logic [31:0] bus;
    } ref_target_t;

    typedef struct packed {
        logic driven;
        pi_word_t value;
    } expect_t;

    logic sys;
    logic rst;
    pi_config_t cfg;
    logic alel;
    logic aleh;
    logic read;
    logic write;
    wire pi_word_t ad;
    pi_word_t ad_drv;
    logic ad_en;

    pi_word_t shadow [2**(MEM_ADDR_BITS-1)];
    expect_t expect_q [$];
    expect_t current;
    int checks = 0;
    int errors = 0;
    int tests_failed = 0;

    assign ad = ad_en ? ad_drv : 'z;

    for (genvar b = 0; b < 16; b++) begin : g_pull
        pullup (ad[b]);
    end

    pi_cart_top i_pi_cart_top (
        .sys(sys),
        .rst(rst),
        .cfg(cfg),
        .alel(alel),
        .aleh(aleh),
        .read(read),
        .write(write),
        .ad(ad)
    );

    initial begin
        sys = 1'b0;
        forever #(PERIOD / 2) sys = ~sys;
    end

    // Console address to bus address by the ROM and save window rules
    function automatic ref_target_t decode_console(input pi_config_t c, input logic [31:0] addr);
        ref_target_t t;
        t = '0;
        if (addr[31:16] >= 16'h1000 && addr[31:16] <= 16'h13ff) begin
            t.valid = 1'b1;
            t.writable = c.rom_writable;
            t.bus = c.rom_offset + (addr - 32'h1000_0000);
        end else if (c.save_enabled && addr[31:16] == 16'h0800 && addr[15:0] < 16'h8000) begin
            t.valid = 1'b1;
            t.writable = 1'b1;
            t.bus = c.save_offset + (addr - 32'h0800_0000);
        end
        t.bus[0] = 1'b0;
        return t;
    endfunction

    function automatic int unsigned word_index(input logic [31:0] bus);
        return int'(bus[MEM_ADDR_BITS-1:1]); // Wraps modulo the memory size
    endfunction

    function automatic pi_word_t ref_read(input logic [31:0] addr);
        ref_target_t t;
        t = decode_console(cfg, addr);
        return shadow[word_index(t.bus)];
    endfunction

    task automatic model_write(input logic [31:0] addr, input pi_word_t data);
        ref_target_t t;
        t = decode_console(cfg, addr);
        if (t.valid && t.writable) begin
            shadow[word_index(t.bus)] = data;
        end
    endtask

    task automatic check_word(input pi_word_t actual, input pi_word_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: ad = %h, expected %h", $time, actual, expected);
        end
    endtask

    task automatic check_undriven(input pi_word_t actual);
        checks++;
        if (actual !== IDLE_AD) begin
            errors++;
            $display("Error at %0t ns: ad = %h, expected undriven (%h)", $time, actual, IDLE_AD);
        end
    endtask

    // Samples land half a cycle after they are queued, where ad is stable
    always @(negedge sys) begin
        if (expect_q.size() != 0) begin
            current = expect_q.pop_front();
            if (current.driven) begin
                check_word(ad, current.value);
            end else begin
                check_undriven(ad);
            end
        end
    end

    task automatic next_drive(input int cycles);
        repeat (cycles) @(posedge sys);
        #DRIVE_DELAY;
    endtask

    // One console transfer of count words starting at addr
    task automatic run_burst(input logic [31:0] addr, input logic is_write, input int count);
        pi_word_t data;
        logic [31:0] word_addr;
        ref_target_t t;
        expect_t e;
        ad_en = 1'b1;
        ad_drv = addr[31:16];
        aleh = 1'b1;
        alel = 1'b1;
        next_drive(PHASE);
        aleh = 1'b0;
        ad_drv = addr[15:0];
        next_drive(PHASE);
        alel = 1'b0;
        ad_en = is_write;
        next_drive(PHASE);
        for (int i = 0; i < count; i++) begin
            word_addr = addr + 32'(2 * i);
            if (is_write) begin
                data = pi_word_t'($urandom % 32'hffff); // Keeps clear of the idle value
                ad_drv = data;
                write = 1'b0;
                model_write(word_addr, data);
                next_drive(STROBE_LOW);
                write = 1'b1;
            end else begin
                read = 1'b0;
                next_drive(STROBE_LOW - 1);
                t = decode_console(cfg, word_addr);
                e.driven = t.valid;
                e.value = t.valid ? ref_read(word_addr) : IDLE_AD;
                expect_q.push_back(e);
                next_drive(1);
                read = 1'b1;
            end
            next_drive(PHASE);
        end
        aleh = 1'b1;
        ad_en = 1'b0;
        next_drive(PHASE);
    endtask

    task automatic end_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int mark;
        void'($urandom(32'hd7386b86));
        rst = 1'b1;
        aleh = 1'b1; // Idle mode
        alel = 1'b0;
        read = 1'b1;
        write = 1'b1;
        ad_en = 1'b0;
        ad_drv = '0;
        cfg = '{save_enabled: 1'b1, rom_writable: 1'b1, rom_offset: 32'h0,
                save_offset: 32'h0000_0800};
        repeat (10) @(posedge sys);
        #DRIVE_DELAY;
        rst = 1'b0;

        mark = errors;
        next_drive(PHASE);
        expect_q.push_back('{driven: 1'b0, value: IDLE_AD});
        next_drive(2);
        end_test("idle bus after reset", mark);

        mark = errors;
        run_burst(32'h1000_0000, 1'b1, 8);
        run_burst(32'h1000_0000, 1'b0, 8);
        end_test("rom write and read back", mark);

        mark = errors;
        run_burst(32'h1000_0100, 1'b1, 16);
        run_burst(32'h1000_0100, 1'b0, 16);
        end_test("rom 16 word read burst", mark);

        mark = errors;
        cfg.rom_writable = 1'b0;
        run_burst(32'h1000_0000, 1'b1, 8);
        run_burst(32'h1000_0000, 1'b0, 8);
        end_test("write to read-only rom dropped", mark);

        mark = errors;
        run_burst(32'h0800_0100, 1'b1, 8);
        run_burst(32'h0800_0100, 1'b0, 8);
        cfg.save_enabled = 1'b0;
        run_burst(32'h0800_0100, 1'b0, 8);
        cfg.save_enabled = 1'b1;
        run_burst(32'h0800_8000, 1'b0, 8);
        end_test("save window", mark);

        mark = errors;
        run_burst(32'h0400_0000, 1'b0, 8);
        end_test("unmapped read", mark);

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 NUM_TESTS, tests_failed, checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== pi_cart.f ====
design/pi_cart_pkg.sv
design/pi_fifo.sv
design/pi_bus_frontend.sv
design/pi_address_decode.sv
design/pi_bus_controller.sv
design/cart_memory.sv
design/pi_cart_top.sv
tests/pi_cart_tb.sv

// ==== Makefile ====
TOP = pi_cart_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f pi_cart.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f pi_cart.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
